// ==== vlog.f ====
rtl/scb_pkg.sv
rtl/scb_entry_ctrl.sv
rtl/scb_data_array.sv
rtl/scb_drain.sv
rtl/store_commit_buffer.sv
tests/tb_store_commit_buffer.sv

// ==== Bender.yml ====
package:
  name: store_commit_buffer

sources:
  - rtl/scb_pkg.sv
  - rtl/scb_entry_ctrl.sv
  - rtl/scb_data_array.sv
  - rtl/scb_drain.sv
  - rtl/store_commit_buffer.sv
  - target: test
    files:
      - tests/tb_store_commit_buffer.sv

// ==== tests/tb_store_commit_buffer.sv ====
`timescale 1ns/1ns

module tb_store_commit_buffer import scb_pkg::*; ();

    localparam int N_MERGE     = 200;
    localparam int N_FULL      = 12;
    localparam int N_MIX       = 200;
    localparam int CYCLE_LIMIT = 30 * (N_MERGE + N_FULL + N_MIX) + 2000;

    logic clk, rst, flush, st_en, ld_en, dc_valid, st_stall, dc_req, empty;
    word_addr_t st_addr, ld_addr;
    bank_mask_t st_mask, ld_fwd_mask;
    bank_data_t st_data, ld_fwd_data;
    dc_resp_e   dc_resp;
    entry_idx_t dc_resp_idx, dc_idx;
    line_addr_t dc_addr;
    line_data_t dc_data;
    line_mask_t dc_mask;

    store_commit_buffer i_dut (.*);

    logic [7:0] ref_mem   [logic [31:0]];  // byte address to last applied byte
    logic [7:0] cache_img [logic [31:0]];
    bit         line_seen [line_addr_t];
    entry_idx_t req_idx_q [$];
    line_addr_t req_addr_q [$];
    line_data_t req_data_q [$];
    line_mask_t req_mask_q [$];
    int err_cnt = 0, misc_cnt = 0, cycle_cnt = 0, resp_wait = 0;
    logic       pend_en = 1'b0, ld_was_en = 1'b0, hold_dc = 1'b0;
    word_addr_t pend_addr, ld_was_addr;
    bank_mask_t pend_mask, ld_exp_mask;
    bank_data_t pend_data, ld_exp_data;

    always #4 clk = ~clk;

    function automatic bank_data_t byte_bits(input bank_mask_t m);
        bank_data_t bits;
        for (int b = 0; b < BANK_BYTES; b++) bits[b*8 +: 8] = {8{m[b]}};
        return bits;
    endfunction

    // expected word from the applied stores and the mask of bytes ever written
    function automatic bank_data_t ref_word(input word_addr_t a, output bank_mask_t stored);
        bank_data_t w;
        w = '0;
        stored = '0;
        for (int b = 0; b < BANK_BYTES; b++) begin
            if (ref_mem.exists({a, 3'(b)})) begin
                w[b*8 +: 8] = ref_mem[{a, 3'(b)}];
                stored[b] = 1'b1;
            end
        end
        return w;
    endfunction

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic word_check(input string name, input bank_data_t got, input bank_data_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic mask_check(input string name, input bank_mask_t got, input bank_mask_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic line_check(input string name, input line_data_t got, input line_data_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // one store plus a load held until the store stage takes it
    task automatic drive_store(input word_addr_t a, input word_addr_t la, input bit no_stall);
        st_en   <= 1'b1;
        st_addr <= a;
        st_mask <= bank_mask_t'($urandom);
        st_data <= {$urandom, $urandom};
        ld_en   <= 1'($urandom);
        ld_addr <= la;
        do begin
            @(posedge clk);
            if (no_stall && st_stall) begin
                $display("st_stall rose although at most %0d lines were in use", SCB_SIZE);
                misc_cnt++;
            end
        end while (st_stall);
    endtask

    // ########################################
    // compare process and reference update
    // ########################################
    always @(posedge clk) begin
        if (rst) begin
            if (ld_was_en) begin
                for (int b = 0; b < BANK_BYTES; b++) begin
                    if (ld_fwd_mask[b] && !ld_exp_mask[b]) begin
                        $display("forwarded byte %0d of word %h was never stored", b, ld_was_addr);
                        misc_cnt++;
                    end
                end
                word_check("ld_fwd_data", ld_fwd_data & byte_bits(ld_fwd_mask & ld_exp_mask),
                           ld_exp_data & byte_bits(ld_fwd_mask & ld_exp_mask));
            end else begin
                mask_check("ld_fwd_mask", ld_fwd_mask, '0);
            end
            ld_was_en   = ld_en;
            ld_was_addr = ld_addr;
            ld_exp_data = ref_word(ld_addr, ld_exp_mask);  // before this edge's store
            if (!st_stall) begin
                if (pend_en) begin
                    for (int b = 0; b < BANK_BYTES; b++)
                        if (pend_mask[b]) ref_mem[{pend_addr, 3'(b)}] = pend_data[b*8 +: 8];
                end
                pend_en   = st_en;
                pend_addr = st_addr;
                pend_mask = st_mask;
                pend_data = st_data;
            end
        end
    end

    // ########################################
    // data cache model
    // ########################################
    always @(posedge clk) begin
        dc_valid <= !hold_dc && ($urandom % 4 != 0);
        dc_resp  <= DC_RESP_NONE;
        if (dc_req && dc_valid) begin
            for (int j = 0; j < BANK_NUM * BANK_BYTES; j++) begin
                if (dc_mask[j] && !ref_mem.exists({dc_addr, 4'(j)})) begin
                    $display("dc_mask byte %0d of line %h was never stored", j, dc_addr);
                    misc_cnt++;
                end
            end
            req_idx_q.push_back(dc_idx);
            req_addr_q.push_back(dc_addr);
            req_data_q.push_back(dc_data);
            req_mask_q.push_back(dc_mask);
        end
        if (resp_wait != 0) begin
            resp_wait--;
        end else if (req_idx_q.size() != 0) begin
            dc_resp_idx <= req_idx_q.pop_front();
            if ($urandom % 5 == 0) begin
                dc_resp <= DC_RESP_CONFLICT;
            end else begin
                dc_resp <= DC_RESP_SUCCESS;
                for (int j = 0; j < BANK_NUM * BANK_BYTES; j++) begin
                    if (req_mask_q[0][j]) begin
                        cache_img[{req_addr_q[0], 4'(j)}] = req_data_q[0][j*8 +: 8];
                    end
                end
            end
            void'(req_addr_q.pop_front());
            void'(req_data_q.pop_front());
            void'(req_mask_q.pop_front());
            resp_wait = $urandom % 6;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with the run unfinished", cycle_cnt);
            $display("errors: %0d value mismatches, %0d other failures", err_cnt, misc_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int stall_wait;
        line_data_t exp_line;
        line_data_t got_line;

        void'($urandom(32'hfeb));
        clk = 1'b0;
        {rst, flush, st_en, ld_en, dc_valid} <= '0;
        {st_addr, st_mask, st_data, ld_addr, dc_resp_idx} <= '0;
        dc_resp <= DC_RESP_NONE;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        flag_check("dc_req", dc_req, 1'b0);
        flag_check("st_stall", st_stall, 1'b0);
        mask_check("ld_fwd_mask", ld_fwd_mask, '0);
        flag_check("empty", empty, 1'b1);

        for (int i = 0; i < N_MERGE; i++)  // six lines only
            drive_store({line_addr_t'(32'h100 + $urandom % 6), 1'($urandom)},
                        {line_addr_t'(32'h100 + $urandom % 6), 1'($urandom)}, 1'b1);
        {st_en, ld_en} <= '0;

        hold_dc <= 1'b1;
        repeat (2) @(posedge clk);
        fork
            for (int i = 0; i < N_FULL; i++)
                drive_store({line_addr_t'(32'h200 + i), i[0]}, {line_addr_t'(32'h200), 1'b0}, 1'b0);
            begin
                stall_wait = 0;
                while (!st_stall && stall_wait < 200) begin
                    @(posedge clk);
                    stall_wait++;
                end
                if (!st_stall) begin
                    $display("st_stall never rose with more lines than entries");
                    misc_cnt++;
                end
                repeat (20) @(posedge clk);
                hold_dc <= 1'b0;
            end
        join
        {st_en, ld_en} <= '0;

        for (int i = 0; i < N_MIX; i++)
            drive_store({line_addr_t'(32'h300 + $urandom % 24), 1'($urandom)},
                        {line_addr_t'(32'h300 + $urandom % 24), 1'($urandom)}, 1'b0);
        {st_en, ld_en} <= '0;
        repeat (3) @(posedge clk);
        flush <= 1'b1;
        while (!empty) @(posedge clk);
        flush <= 1'b0;
        repeat (2) @(posedge clk);

        foreach (ref_mem[k]) line_seen[k[31:4]] = 1'b1;
        foreach (line_seen[ln]) begin
            exp_line = '0;
            got_line = '0;
            for (int j = 0; j < BANK_NUM * BANK_BYTES; j++) begin
                if (ref_mem.exists({ln, 4'(j)})) begin
                    exp_line[j*8 +: 8] = ref_mem[{ln, 4'(j)}];
                    got_line[j*8 +: 8] = cache_img.exists({ln, 4'(j)}) ?
                                         cache_img[{ln, 4'(j)}] : 8'hxx;
                end
            end
            line_check($sformatf("cache_img[%h]", ln), got_line, exp_line);
        end

        $display("errors: %0d value mismatches, %0d other failures", err_cnt, misc_cnt);
        if (err_cnt == 0 && misc_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/store_commit_buffer.sv ====
`timescale 1ns/1ns

module store_commit_buffer import scb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       st_en,
    input  word_addr_t st_addr,
    input  bank_mask_t st_mask,
    input  bank_data_t st_data,
    input  logic       ld_en,
    input  word_addr_t ld_addr,
    input  logic       dc_valid,
    input  dc_resp_e   dc_resp,
    input  entry_idx_t dc_resp_idx,
    output logic       st_stall,
    output bank_mask_t ld_fwd_mask,
    output bank_data_t ld_fwd_data,
    output logic       dc_req,
    output entry_idx_t dc_idx,
    output line_addr_t dc_addr,
    output line_data_t dc_data,
    output line_mask_t dc_mask,
    output logic       empty
);

    // ########################################
    // store stage
    // ########################################
    logic       stg_en;
    word_addr_t stg_addr;
    bank_mask_t stg_mask;
    bank_data_t stg_data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stg_en <= 1'b0;
        end else if (!st_stall) begin
            stg_en <= st_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!st_stall) begin  // held while stalled
            stg_addr <= st_addr;
            stg_mask <= st_mask;
            stg_data <= st_data;
        end
    end

    logic       wr_en;
    entry_idx_t wr_idx;
    logic       wr_new;
    logic       fwd_en;
    entry_idx_t fwd_idx;
    entry_vec_t ready;
    line_addr_t sel_tag;
    logic       sel_en;
    entry_idx_t sel_idx;
    logic       rd_en;
    entry_idx_t rd_idx;
    line_data_t rd_data;
    line_mask_t rd_mask;

    scb_entry_ctrl i_entry_ctrl (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .stg_en         (stg_en),
        .stg_addr       (stg_addr),
        .ld_en          (ld_en),
        .ld_addr        (ld_addr),
        .sel_en         (sel_en),
        .sel_idx        (sel_idx),
        .dc_resp        (dc_resp),
        .dc_resp_idx    (dc_resp_idx),
        .st_stall       (st_stall),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_new         (wr_new),
        .fwd_en         (fwd_en),
        .fwd_idx        (fwd_idx),
        .ready          (ready),
        .line_addr_tags (sel_tag),
        .empty          (empty)
    );

    scb_data_array i_data_array (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_new   (wr_new),
        .wr_idx   (wr_idx),
        .wr_bank  (stg_addr[BANK_W-1:0]),
        .wr_mask  (stg_mask),
        .wr_data  (stg_data),
        .fwd_en   (fwd_en),
        .fwd_idx  (fwd_idx),
        .fwd_bank (ld_addr[BANK_W-1:0]),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .fwd_mask (ld_fwd_mask),
        .fwd_data (ld_fwd_data),
        .rd_data  (rd_data),
        .rd_mask  (rd_mask)
    );

    scb_drain i_drain (
        .clk      (clk),
        .rst      (rst),
        .dc_valid (dc_valid),
        .ready    (ready),
        .dc_resp  (dc_resp),
        .tag      (sel_tag),
        .rd_data  (rd_data),
        .rd_mask  (rd_mask),
        .sel_en   (sel_en),
        .sel_idx  (sel_idx),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .dc_req   (dc_req),
        .dc_idx   (dc_idx),
        .dc_addr  (dc_addr),
        .dc_data  (dc_data),
        .dc_mask  (dc_mask)
    );

endmodule

// ==== rtl/scb_drain.sv ====
`timescale 1ns/1ns

module scb_drain import scb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       dc_valid,
    input  entry_vec_t ready,
    input  dc_resp_e   dc_resp,
    input  line_addr_t tag,
    input  line_data_t rd_data,
    input  line_mask_t rd_mask,
    output logic       sel_en,
    output entry_idx_t sel_idx,
    output logic       rd_en,
    output entry_idx_t rd_idx,
    output logic       dc_req,
    output entry_idx_t dc_idx,
    output line_addr_t dc_addr,
    output line_data_t dc_data,
    output line_mask_t dc_mask
);

    logic [$clog2(RETRY_CYCLES+1)-1:0] backoff;

    logic       s1_req;
    entry_idx_t s1_idx;
    line_addr_t s1_tag;
    logic       s2_req;
    entry_idx_t s2_idx;
    line_addr_t s2_tag;

    // select stage
    assign sel_idx = first_set(ready);
    assign sel_en  = dc_valid && (backoff == '0) && (|ready);

    // read stage
    assign rd_en  = dc_valid;
    assign rd_idx = s1_idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_req  <= 1'b0;
            s2_req  <= 1'b0;
            backoff <= '0;
        end else begin
            if (dc_valid) begin
                s1_req <= sel_en;
                s2_req <= s1_req;
            end
            if (dc_resp == DC_RESP_CONFLICT) begin
                backoff <= ($clog2(RETRY_CYCLES+1))'(RETRY_CYCLES);
            end else if (backoff != '0) begin
                backoff <= backoff - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dc_valid) begin
            s1_idx <= sel_idx;
            s1_tag <= tag;
            s2_idx <= s1_idx;
            s2_tag <= s1_tag;
        end
    end

    // request stage
    assign dc_req  = s2_req;
    assign dc_idx  = s2_idx;
    assign dc_addr = s2_tag;
    assign dc_data = rd_data;
    assign dc_mask = rd_mask;

endmodule

// ==== rtl/scb_data_array.sv ====
`timescale 1ns/1ns

module scb_data_array import scb_pkg::*; (
    input  logic              clk,
    input  logic              wr_en,
    input  logic              wr_new,
    input  entry_idx_t        wr_idx,
    input  logic [BANK_W-1:0] wr_bank,
    input  bank_mask_t        wr_mask,
    input  bank_data_t        wr_data,
    input  logic              fwd_en,
    input  entry_idx_t        fwd_idx,
    input  logic [BANK_W-1:0] fwd_bank,
    input  logic              rd_en,
    input  entry_idx_t        rd_idx,
    output bank_mask_t        fwd_mask,
    output bank_data_t        fwd_data,
    output line_data_t        rd_data,
    output line_mask_t        rd_mask
);

    line_data_t data_q [SCB_SIZE];
    line_mask_t vld_q  [SCB_SIZE];

    line_mask_t line_we;
    line_data_t line_wdata;

    // place the bank word into its half of the line
    assign line_we    = line_mask_t'(wr_mask) << (wr_bank * BANK_BYTES);
    assign line_wdata = {BANK_NUM{wr_data}};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int j = 0; j < BANK_NUM * BANK_BYTES; j++) begin
                if (line_we[j]) begin
                    data_q[wr_idx][j*8 +: 8] <= line_wdata[j*8 +: 8];
                end
            end
            if (wr_new) begin
                vld_q[wr_idx] <= line_we;  // fresh entry drops stale bytes
            end else begin
                vld_q[wr_idx] <= vld_q[wr_idx] | line_we;
            end
        end
    end

    // ########################################
    // read ports
    // ########################################
    always_ff @(posedge clk) begin
        if (fwd_en) begin
            fwd_data <= data_q[fwd_idx][fwd_bank*BANK_BYTES*8 +: BANK_BYTES*8];
            fwd_mask <= vld_q[fwd_idx][fwd_bank*BANK_BYTES +: BANK_BYTES];
        end else begin
            fwd_mask <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin  // follows the drain pipe
            rd_data <= data_q[rd_idx];
            rd_mask <= vld_q[rd_idx];
        end
    end

endmodule

// ==== rtl/scb_entry_ctrl.sv ====
`timescale 1ns/1ns

module scb_entry_ctrl import scb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       stg_en,
    input  word_addr_t stg_addr,
    input  logic       ld_en,
    input  word_addr_t ld_addr,
    input  logic       sel_en,
    input  entry_idx_t sel_idx,
    input  dc_resp_e   dc_resp,
    input  entry_idx_t dc_resp_idx,
    output logic       st_stall,
    output logic       wr_en,
    output entry_idx_t wr_idx,
    output logic       wr_new,
    output logic       fwd_en,
    output entry_idx_t fwd_idx,
    output entry_vec_t ready,
    output line_addr_t line_addr_tags,
    output logic       empty
);

    line_addr_t tags [SCB_SIZE];
    logic [AGE_W-1:0] age [SCB_SIZE];
    entry_vec_t addr_valid;
    entry_vec_t dirty;
    entry_vec_t writing;
    logic [SCB_IDX_W:0] occ_cnt;  // registered occupancy
    logic [SCB_IDX_W:0] occ_next;

    line_addr_t stg_line;
    line_addr_t ld_line;
    entry_vec_t hit_vec;
    entry_vec_t fwd_vec;
    entry_vec_t wr_vec;
    entry_vec_t sel_vec;
    entry_vec_t resp_vec;
    entry_vec_t conf_vec;
    entry_vec_t drained;
    entry_idx_t hit_idx;
    entry_idx_t free_idx;
    logic hit;
    logic full;
    logic occ_over;

    // ########################################
    // store match and allocation
    // ########################################
    assign stg_line = stg_addr[PADDR_W-BYTE_W-1:BANK_W];

    always_comb begin
        for (int i = 0; i < SCB_SIZE; i++) begin
            hit_vec[i] = addr_valid[i] && (tags[i] == stg_line);
        end
    end

    assign hit      = |hit_vec;
    assign full     = &addr_valid;
    assign hit_idx  = first_set(hit_vec);
    assign free_idx = first_set(~addr_valid);

    assign st_stall = stg_en && !hit && full;
    assign wr_en    = stg_en && (hit || !full);
    assign wr_new   = !hit;
    assign wr_idx   = hit ? hit_idx : free_idx;
    assign empty    = ~|addr_valid;

    always_ff @(posedge clk) begin
        if (wr_en && wr_new) begin
            tags[free_idx] <= stg_line;
        end
    end

    // ########################################
    // load forward match
    // ########################################
    assign ld_line = ld_addr[PADDR_W-BYTE_W-1:BANK_W];

    always_comb begin
        for (int i = 0; i < SCB_SIZE; i++) begin
            fwd_vec[i] = ld_en && addr_valid[i] && (tags[i] == ld_line);
        end
    end

    assign fwd_en  = |fwd_vec;
    assign fwd_idx = first_set(fwd_vec);

    // ########################################
    // aging and drain readiness
    // ########################################
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < SCB_SIZE; i++) begin
                age[i] <= AGE_W'(1);
            end
        end else if (wr_en) begin
            for (int i = 0; i < SCB_SIZE; i++) begin
                if (wr_idx == entry_idx_t'(i)) begin
                    age[i] <= '1;
                end else if (age[i] != AGE_W'(1)) begin
                    age[i] <= age[i] - AGE_W'(1);
                end
            end
        end
    end

    always_comb begin
        occ_next = '0;
        for (int i = 0; i < SCB_SIZE; i++) begin
            occ_next = occ_next + (SCB_IDX_W+1)'(addr_valid[i]);
        end
    end

    assign occ_over = occ_cnt > DRAIN_THRESH;

    always_comb begin
        for (int i = 0; i < SCB_SIZE; i++) begin
            ready[i] = ((age[i] == AGE_W'(1)) || occ_over || flush)
                       && addr_valid[i] && dirty[i] && !writing[i];
        end
    end

    assign line_addr_tags = tags[sel_idx];

    // ########################################
    // entry state
    // ########################################
    assign wr_vec   = entry_vec_t'(wr_en) << wr_idx;
    assign sel_vec  = entry_vec_t'(sel_en) << sel_idx;
    assign resp_vec = entry_vec_t'(dc_resp != DC_RESP_NONE) << dc_resp_idx;
    assign conf_vec = entry_vec_t'(dc_resp == DC_RESP_CONFLICT) << dc_resp_idx;
    assign drained  = addr_valid & ~dirty & ~writing;  // written back, free it

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            addr_valid <= '0;
            dirty      <= '0;
            writing    <= '0;
            occ_cnt    <= '0;
        end else begin
            addr_valid <= (addr_valid & ~drained) | wr_vec;
            dirty      <= (dirty & ~sel_vec) | wr_vec | conf_vec;  // conflict redirties
            writing    <= (writing | sel_vec) & ~resp_vec;
            occ_cnt    <= occ_next;
        end
    end

endmodule

// ==== rtl/scb_pkg.sv ====
package scb_pkg;

    // ########################################
    // sizes
    // ########################################
    localparam int SCB_SIZE     = 8;
    localparam int SCB_IDX_W    = 3;
    localparam int PADDR_W      = 32;
    localparam int BYTE_W       = 3;  // byte offset in a bank word
    localparam int BANK_NUM     = 2;
    localparam int BANK_W       = 1;
    localparam int BANK_BYTES   = 8;
    localparam int AGE_W        = 4;
    localparam int DRAIN_THRESH = 5;  // occupancy that forces a drain
    localparam int RETRY_CYCLES = 3;

    // ########################################
    // types
    // ########################################
    typedef logic [PADDR_W-BYTE_W-1:0]        word_addr_t;
    typedef logic [PADDR_W-BYTE_W-BANK_W-1:0] line_addr_t;
    typedef logic [SCB_IDX_W-1:0]             entry_idx_t;
    typedef logic [SCB_SIZE-1:0]              entry_vec_t;
    typedef logic [BANK_BYTES*8-1:0]          bank_data_t;
    typedef logic [BANK_BYTES-1:0]            bank_mask_t;
    typedef logic [BANK_NUM*BANK_BYTES*8-1:0] line_data_t;
    typedef logic [BANK_NUM*BANK_BYTES-1:0]   line_mask_t;

    typedef enum logic [1:0] {
        DC_RESP_NONE     = 2'd0,
        DC_RESP_SUCCESS  = 2'd1,
        DC_RESP_CONFLICT = 2'd2
    } dc_resp_e;

    // lowest set bit wins
    function automatic entry_idx_t first_set(input entry_vec_t vec);
        entry_idx_t idx;
        idx = '0;
        for (int i = SCB_SIZE - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = entry_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage
